// File: list.f
+incdir+.
sata_types_pkg.sv
sata_link_pkg.sv
sata_ifs.sv
shadow_regs.sv
fis_tx_datapath.sv
dword_counter.sv
link_tx_fsm.sv
sata_host_tx.sv
tb_checker.sv
tb_sata_host_tx.sv

// File: Makefile
# Verilator build and run for the SATA host transmit testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_host_tx
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= *** TEST PASSED ***

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: tb_patterns.hex
// columns: feature lba_lo lba_hi count command dev control, then expected FIS dwords 0 to 4
// one Register H2D command per line, all values in hex
0000 000000 000000 0000 EC A0 08 00EC8027 A0000000 00000000 08000000 00000000
1234 563412 00AB90 0080 25 40 00 34258027 40563412 1200AB90 00000080 00000000
00FF FFFFFF FFFFFF FFFF 35 E0 04 FF358027 E0FFFFFF 00FFFFFF 0400FFFF 00000000
A55A 0F1E2D 3C4B5A 1001 C8 5E 02 5AC88027 5E0F1E2D A53C4B5A 02001001 00000000
0003 000001 800000 0200 61 40 00 03618027 40000001 00800000 00000200 00000000
C301 9ABCDE 12345F 7E01 EF B0 80 01EF8027 B09ABCDE C312345F 80007E01 00000000

// File: tb_sata_host_tx.sv
// runs each line of tb_patterns.hex as one command; device_hold is random, inputs move 1 ns after posedge
module tb_sata_host_tx import sata_types_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_patterns   = 6;
    // seven register values, then five expected dwords
    localparam int pattern_cols   = 12;
    localparam int timeout_cycles = num_patterns * 64 + 100;

    logic         clk = 1'b0;
    logic         reset;
    sh_feature_t  sh_feature;
    sh_half_lba_t sh_lba_lo;
    sh_half_lba_t sh_lba_hi;
    sh_count_t    sh_count;
    sh_byte_t     sh_command;
    sh_byte_t     sh_dev;
    sh_byte_t     sh_control;
    logic         sh_feature_wr;
    logic         sh_lba_lo_wr;
    logic         sh_lba_hi_wr;
    logic         sh_count_wr;
    logic         sh_command_wr;
    logic         sh_dev_wr;
    logic         sh_control_wr;
    logic         cmd_val;
    logic         cmd_busy;
    logic         cmd_done;
    logic         phy_ready;
    logic         device_hold;
    dword_t       phy_data;
    isk_t         phy_isk;

    logic [31:0] pattern_mem [num_patterns * pattern_cols];
    logic [31:0] hold_lfsr = 32'h5b0e671c;
    int          tb_errors = 0;
    int          commands  = 0;
    int          total_errors;

    always #5 clk = ~clk;

    sata_host_tx dut (
        .clk           (clk),
        .reset         (reset),
        .sh_feature    (sh_feature),
        .sh_feature_wr (sh_feature_wr),
        .sh_lba_lo     (sh_lba_lo),
        .sh_lba_lo_wr  (sh_lba_lo_wr),
        .sh_lba_hi     (sh_lba_hi),
        .sh_lba_hi_wr  (sh_lba_hi_wr),
        .sh_count      (sh_count),
        .sh_count_wr   (sh_count_wr),
        .sh_command    (sh_command),
        .sh_command_wr (sh_command_wr),
        .sh_dev        (sh_dev),
        .sh_dev_wr     (sh_dev_wr),
        .sh_control    (sh_control),
        .sh_control_wr (sh_control_wr),
        .cmd_val       (cmd_val),
        .cmd_busy      (cmd_busy),
        .cmd_done      (cmd_done),
        .phy_ready     (phy_ready),
        .device_hold   (device_hold),
        .phy_data      (phy_data),
        .phy_isk       (phy_isk)
    );

    tb_checker stream_check (
        .clk      (clk),
        .reset    (reset),
        .phy_data (phy_data),
        .phy_isk  (phy_isk),
        .cmd_busy (cmd_busy),
        .cmd_done (cmd_done)
    );

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per hold bit
    always @(posedge clk) begin
        #1;
        hold_lfsr   = lfsr_next(hold_lfsr);
        device_hold = hold_lfsr[0];
    end

    // sel bit order: control dev command count lba_hi lba_lo feature
    task automatic strobe_writes(input logic [6:0] sel);
        {sh_control_wr, sh_dev_wr, sh_command_wr, sh_count_wr,
         sh_lba_hi_wr, sh_lba_lo_wr, sh_feature_wr} = sel;
        @(posedge clk);
        #1;
        {sh_control_wr, sh_dev_wr, sh_command_wr, sh_count_wr,
         sh_lba_hi_wr, sh_lba_lo_wr, sh_feature_wr} = '0;
    endtask

    task automatic write_registers(input int pat, input logic split);
        int base;
        base       = pat * pattern_cols;
        sh_feature = pattern_mem[base][15:0];
        sh_lba_lo  = pattern_mem[base + 1][23:0];
        sh_lba_hi  = pattern_mem[base + 2][23:0];
        sh_count   = pattern_mem[base + 3][15:0];
        sh_command = pattern_mem[base + 4][7:0];
        sh_dev     = pattern_mem[base + 5][7:0];
        sh_control = pattern_mem[base + 6][7:0];
        if (split) begin
            // pairs of strobes, the LBA halves on different edges
            strobe_writes(7'b0000011);
            strobe_writes(7'b0001100);
            strobe_writes(7'b0110000);
            strobe_writes(7'b1000000);
        end else begin
            strobe_writes(7'b1111111);
        end
    endtask

    task automatic load_expected(input int pat);
        int base;
        base = pat * pattern_cols + 7;
        stream_check.push_expected(pattern_mem[base], pattern_mem[base + 1],
                                   pattern_mem[base + 2], pattern_mem[base + 3],
                                   pattern_mem[base + 4]);
    endtask

    task automatic issue_command();
        cmd_val = 1'b1;
        @(posedge clk);
        #1;
        cmd_val = 1'b0;
    endtask

    // cmd_val with the PHY down must be dropped
    task automatic try_command_not_ready();
        phy_ready = 1'b0;
        issue_command();
        repeat (2) @(posedge clk);
        #1;
        phy_ready = 1'b1;
    endtask

    task automatic wait_until_idle();
        do begin
            @(posedge clk);
            #1;
        end while (cmd_busy);
    endtask

    initial begin
        reset       = 1'b1;
        cmd_val     = 1'b0;
        phy_ready   = 1'b1;
        device_hold = 1'b0;
        {sh_feature, sh_lba_lo, sh_lba_hi, sh_count} = '0;
        {sh_command, sh_dev, sh_control} = '0;
        {sh_control_wr, sh_dev_wr, sh_command_wr, sh_count_wr,
         sh_lba_hi_wr, sh_lba_lo_wr, sh_feature_wr} = '0;
        for (int a = 0; a < num_patterns * pattern_cols; a++) begin
            pattern_mem[a] = 32'hBAD00000 | a;
        end
        $readmemh("tb_patterns.hex", pattern_mem);
        // last entry still holding its fill value means a short or missing file
        if (pattern_mem[num_patterns * pattern_cols - 1] ===
            (32'hBAD00000 | (num_patterns * pattern_cols - 1))) begin
            $display("ERROR: tb_patterns.hex is missing or holds fewer than %0d lines",
                     num_patterns);
            tb_errors++;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        write_registers(0, 1'b0);
        for (int i = 0; i < num_patterns; i++) begin
            if (i % 2 == 1) begin
                try_command_not_ready();
            end
            load_expected(i);
            issue_command();
            // second pulse lands while busy and must be ignored
            issue_command();
            // next pattern written during this frame, must not leak into it
            if (i + 1 < num_patterns) begin
                write_registers(i + 1, (i % 2) == 0);
            end
            wait_until_idle();
            commands++;
        end
        repeat (4) @(posedge clk);
        stream_check.final_check(commands);
        total_errors = tb_errors + stream_check.error_count;
        $display("summary: %0d errors, %0d frames, %0d hold words, %0d done pulses",
                 total_errors, stream_check.frame_count, stream_check.hold_count,
                 stream_check.done_count);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the pattern count
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles, the DUT seems stuck",
                 timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb_checker.sv
// samples DUT outputs on the falling edge; frames must arrive in the order push_expected was called
`include "sata_params.svh"

module tb_checker import sata_types_pkg::*, sata_link_pkg::*; (
    input logic   clk,
    input logic   reset,
    input dword_t phy_data,
    input isk_t   phy_isk,
    input logic   cmd_busy,
    input logic   cmd_done
);

    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;
    int frame_count = 0;
    int sof_count   = 0;
    int hold_count  = 0;
    int done_count  = 0;

    // expected dwords, five per outstanding command
    dword_t exp_q [$];
    dword_t cur_exp [5];
    // data words of the open frame, holds removed
    dword_t words [$];
    logic   in_frame  = 1'b0;
    logic   have_exp  = 1'b0;
    logic   last_hold = 1'b0;
    logic   prev_eof  = 1'b0;
    logic   prev_busy = 1'b0;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic push_expected(input dword_t d0, input dword_t d1, input dword_t d2,
                                 input dword_t d3, input dword_t d4);
        exp_q.push_back(d0);
        exp_q.push_back(d1);
        exp_q.push_back(d2);
        exp_q.push_back(d3);
        exp_q.push_back(d4);
    endtask

    // SATA CRC-32 over the five FIS dwords, MSB first, no reflection, no final xor
    function automatic dword_t frame_crc(input dword_t dws [5]);
        dword_t r;
        logic   top;
        r = `SATA_CRC_INIT;
        foreach (dws[w]) begin
            for (int b = 31; b >= 0; b--) begin
                top = r[31] ^ dws[w][b];
                r   = r << 1;
                if (top) begin
                    r = r ^ `SATA_CRC_POLY;
                end
            end
        end
        return r;
    endfunction

    task automatic open_frame();
        sof_count++;
        in_frame  = 1'b1;
        last_hold = 1'b0;
        words.delete();
        if (cmd_busy !== 1'b1) begin
            report_mismatch("cmd_busy at SOF", 32'h1, 32'(cmd_busy));
        end
        // a refused or ignored cmd_val leaves nothing queued
        if (exp_q.size() < 5) begin
            report_failure("SOF sent with no command outstanding");
            have_exp = 1'b0;
        end else begin
            for (int k = 0; k < 5; k++) begin
                cur_exp[k] = exp_q.pop_front();
            end
            have_exp = 1'b1;
        end
    endtask

    task automatic close_frame();
        dword_t crc_exp;
        frame_count++;
        if (last_hold) begin
            report_failure("HOLD sent directly before EOF instead of the CRC");
        end
        if (words.size() != 6) begin
            report_failure($sformatf("frame carried %0d data words instead of 6", words.size()));
        end else if (have_exp) begin
            for (int k = 0; k < 5; k++) begin
                if (words[k] !== cur_exp[k]) begin
                    report_mismatch($sformatf("phy_data dword %0d", k), cur_exp[k], words[k]);
                end
            end
            crc_exp = frame_crc(cur_exp);
            if (words[5] !== crc_exp) begin
                report_mismatch("phy_data crc", crc_exp, words[5]);
            end
        end
    endtask

    always @(negedge clk) begin
        // done comes one cycle after EOF, on the cycle busy drops
        if (cmd_done === 1'b1) begin
            done_count++;
            if (!prev_eof) begin
                report_failure("cmd_done without EOF in the previous cycle");
            end
            if (!prev_busy || cmd_busy) begin
                report_failure("cmd_done not aligned with cmd_busy falling");
            end
        end else if (prev_eof) begin
            report_failure("no cmd_done in the cycle after EOF");
        end
        prev_eof = 1'b0;
        if (!in_frame) begin
            if (phy_data == prim_sof && phy_isk == `SATA_ISK_PRIM && !reset) begin
                open_frame();
            end else begin
                // idle line carries SYNC only
                if (phy_data !== prim_sync) begin
                    report_mismatch("phy_data idle", prim_sync, phy_data);
                end
                if (phy_isk !== `SATA_ISK_PRIM) begin
                    report_mismatch("phy_isk idle", 32'(`SATA_ISK_PRIM), 32'(phy_isk));
                end
                if (cmd_busy !== 1'b0) begin
                    report_mismatch("cmd_busy idle", 32'h0, 32'(cmd_busy));
                end
            end
        end else begin
            if (cmd_busy !== 1'b1) begin
                report_mismatch("cmd_busy in frame", 32'h1, 32'(cmd_busy));
            end
            if (phy_isk === `SATA_ISK_DATA) begin
                words.push_back(phy_data);
                last_hold = 1'b0;
            end else if (phy_isk === `SATA_ISK_PRIM && phy_data === prim_hold) begin
                hold_count++;
                last_hold = 1'b1;
            end else if (phy_isk === `SATA_ISK_PRIM && phy_data === prim_eof) begin
                close_frame();
                in_frame = 1'b0;
                prev_eof = 1'b1;
            end else begin
                report_failure($sformatf("unexpected word %h with isk %h inside a frame",
                                         phy_data, phy_isk));
            end
        end
        prev_busy = cmd_busy;
    end

    task automatic final_check(input int commands);
        if (in_frame) begin
            report_failure("run ended inside an open frame");
        end
        if (sof_count != commands) begin
            report_failure($sformatf("%0d SOF words for %0d commands", sof_count, commands));
        end
        if (done_count != commands) begin
            report_failure($sformatf("%0d cmd_done pulses for %0d commands", done_count, commands));
        end
        if (exp_q.size() != 0) begin
            report_failure("expected frames were never sent");
        end
    endtask

endmodule

// File: sata_host_tx.sv
// transmit half of a SATA host: Register H2D FIS only, unscrambled, one frame in flight at a time
module sata_host_tx import sata_types_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // shadow register writes
    input  sh_feature_t  sh_feature,
    input  logic         sh_feature_wr,
    input  sh_half_lba_t sh_lba_lo,
    input  logic         sh_lba_lo_wr,
    input  sh_half_lba_t sh_lba_hi,
    input  logic         sh_lba_hi_wr,
    input  sh_count_t    sh_count,
    input  logic         sh_count_wr,
    input  sh_byte_t     sh_command,
    input  logic         sh_command_wr,
    input  sh_byte_t     sh_dev,
    input  logic         sh_dev_wr,
    input  sh_byte_t     sh_control,
    input  logic         sh_control_wr,
    // command strobe and status
    input  logic         cmd_val,
    output logic         cmd_busy,
    output logic         cmd_done,
    // PHY side
    input  logic         phy_ready,
    input  logic         device_hold,
    output dword_t       phy_data,
    output isk_t         phy_isk
);

    shadow_if sh_bus ();
    fis_tx_if tx_bus ();

    logic cnt_clear;
    logic cnt_step;
    logic cnt_last;

    shadow_regs shadow_regs (
        .clk           (clk),
        .reset         (reset),
        .sh_feature    (sh_feature),
        .sh_feature_wr (sh_feature_wr),
        .sh_lba_lo     (sh_lba_lo),
        .sh_lba_lo_wr  (sh_lba_lo_wr),
        .sh_lba_hi     (sh_lba_hi),
        .sh_lba_hi_wr  (sh_lba_hi_wr),
        .sh_count      (sh_count),
        .sh_count_wr   (sh_count_wr),
        .sh_command    (sh_command),
        .sh_command_wr (sh_command_wr),
        .sh_dev        (sh_dev),
        .sh_dev_wr     (sh_dev_wr),
        .sh_control    (sh_control),
        .sh_control_wr (sh_control_wr),
        .sh            (sh_bus.src)
    );

    // FIS image and CRC
    fis_tx_datapath fis_tx_datapath (
        .clk   (clk),
        .reset (reset),
        .sh    (sh_bus.dst),
        .tx    (tx_bus.data)
    );

    // index feeds the datapath select directly
    dword_counter dword_counter (
        .clk   (clk),
        .reset (reset),
        .clear (cnt_clear),
        .step  (cnt_step),
        .idx   (tx_bus.idx),
        .last  (cnt_last)
    );

    link_tx_fsm link_tx_fsm (
        .clk         (clk),
        .reset       (reset),
        .cmd_val     (cmd_val),
        .phy_ready   (phy_ready),
        .device_hold (device_hold),
        .cnt_last    (cnt_last),
        .cnt_clear   (cnt_clear),
        .cnt_step    (cnt_step),
        .tx          (tx_bus.ctrl),
        .cmd_busy    (cmd_busy),
        .cmd_done    (cmd_done),
        .phy_data    (phy_data),
        .phy_isk     (phy_isk)
    );

endmodule

// File: link_tx_fsm.sv
// transmit only: no receiver handshake, no scrambling; HOLD is honoured in data and crc phases only
`include "sata_params.svh"

module link_tx_fsm import sata_types_pkg::*, sata_link_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   cmd_val,
    input  logic   phy_ready,
    input  logic   device_hold,
    input  logic   cnt_last,
    output logic   cnt_clear,
    output logic   cnt_step,
    fis_tx_if.ctrl tx,
    output logic   cmd_busy,
    output logic   cmd_done,
    output dword_t phy_data,
    output isk_t   phy_isk
);

    link_state_t state;
    logic        accept;
    logic        send_dw;

    // new command only from idle, with the PHY up
    assign accept = (state == link_idle) && cmd_val && phy_ready && !cmd_busy;

    // a FIS dword goes out right after SOF and on every data cycle without hold
    assign send_dw = (state == link_sof) || ((state == link_data) && !device_hold);

    assign tx.start   = accept;
    assign tx.advance = send_dw;
    assign cnt_clear  = accept;
    assign cnt_step   = send_dw;

    // output words are registered, one per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= link_idle;
            cmd_busy <= 1'b0;
            cmd_done <= 1'b0;
            phy_data <= prim_sync;
            phy_isk  <= `SATA_ISK_PRIM;
        end else begin
            // done is a single-cycle pulse
            cmd_done <= 1'b0;
            case (state)
                link_idle: begin
                    phy_data <= prim_sync;
                    phy_isk  <= `SATA_ISK_PRIM;
                    if (accept) begin
                        state    <= link_sof;
                        cmd_busy <= 1'b1;
                        phy_data <= prim_sof;
                    end
                end
                // first dword always follows SOF directly
                link_sof: begin
                    phy_data <= tx.dword;
                    phy_isk  <= `SATA_ISK_DATA;
                    state    <= cnt_last ? link_crc : link_data;
                end
                link_data: begin
                    if (device_hold) begin
                        phy_data <= prim_hold;
                        phy_isk  <= `SATA_ISK_PRIM;
                    end else begin
                        phy_data <= tx.dword;
                        phy_isk  <= `SATA_ISK_DATA;
                        if (cnt_last) begin
                            state <= link_crc;
                        end
                    end
                end
                // CRC register has taken the last dword by now
                link_crc: begin
                    if (device_hold) begin
                        phy_data <= prim_hold;
                        phy_isk  <= `SATA_ISK_PRIM;
                    end else begin
                        phy_data <= tx.crc;
                        phy_isk  <= `SATA_ISK_DATA;
                        state    <= link_eof;
                    end
                end
                link_eof: begin
                    phy_data <= prim_eof;
                    phy_isk  <= `SATA_ISK_PRIM;
                    state    <= link_done;
                end
                // busy drops together with the done pulse
                link_done: begin
                    phy_data <= prim_sync;
                    phy_isk  <= `SATA_ISK_PRIM;
                    cmd_busy <= 1'b0;
                    cmd_done <= 1'b1;
                    state    <= link_idle;
                end
                default: begin
                    state <= link_idle;
                end
            endcase
        end
    end

endmodule

// File: dword_counter.sv
// frame length is fixed at the Register H2D FIS size; clear takes priority over step
`include "sata_params.svh"

module dword_counter import sata_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     clear,
    input  logic     step,
    output fis_idx_t idx,
    output logic     last
);

    // index of the next dword to send
    always_ff @(posedge clk) begin
        if (reset) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (step) begin
            idx <= idx + fis_idx_t'(1);
        end
    end

    // high while the dword about to go out closes the FIS
    assign last = (idx == fis_idx_t'(`SATA_FIS_REG_H2D_DWORDS - 1));

endmodule

// File: fis_tx_datapath.sv
// builds a Register H2D FIS only; the CRC is seeded per frame and has no reflection or inversion
`include "sata_params.svh"

module fis_tx_datapath import sata_types_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    shadow_if.dst  sh,
    fis_tx_if.data tx
);

    // frame image, frozen for the whole frame
    // dword 4 is reserved zero and is not stored
    dword_t fis_dw [`SATA_FIS_REG_H2D_DWORDS - 1];
    // running CRC
    dword_t crc_q;

    // one dword through the CRC-32 shift register, MSB first
    function automatic dword_t crc_fold(input dword_t crc_in, input dword_t data);
        dword_t c;
        logic   fb;
        c = crc_in;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ `SATA_CRC_POLY;
            end
        end
        return c;
    endfunction

    // snapshot of the shadow registers at command accept
    // later writes wait for the next frame
    always_ff @(posedge clk) begin
        if (tx.start) begin
            // feature low, command, C bit, FIS type
            fis_dw[0] <= {sh.feature[7:0], sh.command, `SATA_FIS_C_BIT, `SATA_FIS_TYPE_REG_H2D};
            // device, LBA 23:0
            fis_dw[1] <= {sh.dev, sh.lba[23:0]};
            // feature high, LBA 47:24
            fis_dw[2] <= {sh.feature[15:8], sh.lba[47:24]};
            // control, reserved byte, sector count
            fis_dw[3] <= {sh.control, 8'h00, sh.count};
        end
    end

    // dword selected by the counter; reserved dword 4 and past the end read as zero
    always_comb begin
        case (tx.idx)
            3'd0:    tx.dword = fis_dw[0];
            3'd1:    tx.dword = fis_dw[1];
            3'd2:    tx.dword = fis_dw[2];
            3'd3:    tx.dword = fis_dw[3];
            default: tx.dword = '0;
        endcase
    end

    // seed at start, fold each dword as it goes out
    always_ff @(posedge clk) begin
        if (reset) begin
            crc_q <= `SATA_CRC_INIT;
        end else if (tx.start) begin
            crc_q <= `SATA_CRC_INIT;
        end else if (tx.advance) begin
            crc_q <= crc_fold(crc_q, tx.dword);
        end
    end

    // valid as the final CRC once the last dword has been folded
    assign tx.crc = crc_q;

endmodule

// File: shadow_regs.sv
// write-only register file; no read-back and no device-side updates of the shadow registers
module shadow_regs import sata_types_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  sh_feature_t  sh_feature,
    input  logic         sh_feature_wr,
    input  sh_half_lba_t sh_lba_lo,
    input  logic         sh_lba_lo_wr,
    input  sh_half_lba_t sh_lba_hi,
    input  logic         sh_lba_hi_wr,
    input  sh_count_t    sh_count,
    input  logic         sh_count_wr,
    input  sh_byte_t     sh_command,
    input  logic         sh_command_wr,
    input  sh_byte_t     sh_dev,
    input  logic         sh_dev_wr,
    input  sh_byte_t     sh_control,
    input  logic         sh_control_wr,
    shadow_if.src        sh
);

    // the two LBA halves are kept apart so each strobe touches only its own bits
    sh_half_lba_t lba_lo_q;
    sh_half_lba_t lba_hi_q;

    // each strobe is independent, several may land on one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            sh.feature <= '0;
            lba_lo_q   <= '0;
            lba_hi_q   <= '0;
            sh.count   <= '0;
            sh.command <= '0;
            sh.dev     <= '0;
            sh.control <= '0;
        end else begin
            if (sh_feature_wr) begin
                sh.feature <= sh_feature;
            end
            if (sh_lba_lo_wr) begin
                lba_lo_q <= sh_lba_lo;
            end
            if (sh_lba_hi_wr) begin
                lba_hi_q <= sh_lba_hi;
            end
            if (sh_count_wr) begin
                sh.count <= sh_count;
            end
            if (sh_command_wr) begin
                sh.command <= sh_command;
            end
            if (sh_dev_wr) begin
                sh.dev <= sh_dev;
            end
            if (sh_control_wr) begin
                sh.control <= sh_control;
            end
        end
    end

    // full 48-bit address, upper half in the high bits
    assign sh.lba = {lba_hi_q, lba_lo_q};

endmodule

// File: sata_ifs.sv
// shadow values are plain levels with no valid flag; fis_tx_if assumes one frame at a time
interface shadow_if import sata_types_pkg::*; ();

    sh_feature_t feature;
    sh_lba_t     lba;
    sh_count_t   count;
    sh_byte_t    command;
    sh_byte_t    dev;
    sh_byte_t    control;

    // register file side
    modport src (
        output feature, lba, count, command, dev, control
    );

    // FIS builder side
    modport dst (
        input feature, lba, count, command, dev, control
    );

endinterface

interface fis_tx_if import sata_types_pkg::*; ();

    // latch FIS and reseed CRC, one cycle
    logic     start;
    // fold the presented dword into the CRC
    logic     advance;
    // driven by the dword counter
    fis_idx_t idx;
    dword_t   dword;
    dword_t   crc;

    modport ctrl (
        output start, advance,
        input  dword, crc
    );

    modport data (
        input  start, advance, idx,
        output dword, crc
    );

endinterface

// File: sata_link_pkg.sv
// primitive codes are unscrambled 32-bit words with the K character in byte 0
package sata_link_pkg;

    // link primitives sent by the transmitter
    // byte 0 is K28.3 in all of them
    typedef enum logic [31:0] {
        prim_sync = 32'hB5B5957C,
        prim_sof  = 32'h3737B57C,
        prim_eof  = 32'hD5D5B57C,
        prim_hold = 32'hD5D5AA7C
    } prim_t;

    // transmit FSM phases
    // sof: SOF on the line, first dword goes next
    // data: FIS dwords are being sent
    // crc: last dword is out, CRC goes next
    // eof: CRC is out, EOF goes next
    // done: EOF is out, back to SYNC
    typedef enum logic [2:0] {
        link_idle,
        link_sof,
        link_data,
        link_crc,
        link_eof,
        link_done
    } link_state_t;

endpackage

// File: sata_types_pkg.sv
// widths follow the ATA shadow register layout; a 32-bit PHY word and up to 8 dwords per FIS
package sata_types_pkg;

    // one word at the PHY boundary
    typedef logic [31:0] dword_t;
    // charisk, one bit per byte of a dword
    typedef logic [3:0]  isk_t;

    // 48-bit LBA as the device sees it
    typedef logic [47:0] sh_lba_t;
    // lower or upper 24 bits, written separately
    typedef logic [23:0] sh_half_lba_t;
    typedef logic [15:0] sh_count_t;
    typedef logic [15:0] sh_feature_t;
    // command, device and control are single bytes
    typedef logic [7:0]  sh_byte_t;

    // dword position inside a FIS
    typedef logic [2:0]  fis_idx_t;

endpackage

// File: sata_params.svh
// fixed values for a five-dword Register H2D FIS with SATA CRC-32; other FIS types are not covered
`ifndef SATA_PARAMS_SVH
`define SATA_PARAMS_SVH

// FIS type code of a Register Host-to-Device FIS
`define SATA_FIS_TYPE_REG_H2D   8'h27

// dwords in a Register H2D FIS, CRC not counted
`define SATA_FIS_REG_H2D_DWORDS 5

// C bit set means the FIS carries a command register update
`define SATA_FIS_C_BIT          8'h80

// seed of the frame CRC
`define SATA_CRC_INIT           32'h52325032

// CRC-32 generator, non-reflected form
`define SATA_CRC_POLY           32'h04C11DB7

// charisk nibbles: primitives hold a K character in byte 0 only
`define SATA_ISK_PRIM           4'b0001
`define SATA_ISK_DATA           4'b0000

`endif
